//--- hdl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------
	localparam int addr_width = 32;
	localparam int data_width = 32;
	localparam int bus_width = 64;
	localparam int lane_count = 8;
	localparam int tag_width = 4;
	localparam int op_width = 4;
	localparam int state_width = 3;

	// request operations, top bit marks a store
	localparam logic [op_width-1:0] op_lw = 4'h0;
	localparam logic [op_width-1:0] op_lh = 4'h1;
	localparam logic [op_width-1:0] op_lhu = 4'h2;
	localparam logic [op_width-1:0] op_lb = 4'h3;
	localparam logic [op_width-1:0] op_lbu = 4'h4;
	localparam logic [op_width-1:0] op_sw = 4'h8;
	localparam logic [op_width-1:0] op_sh = 4'h9;
	localparam logic [op_width-1:0] op_sb = 4'ha;

	// bus size encodings
	localparam logic [2:0] size_byte = 3'd0;
	localparam logic [2:0] size_half = 3'd1;
	localparam logic [2:0] size_word = 3'd2;

	localparam logic [1:0] resp_okay = 2'b00;

	// access sequencer states
	localparam logic [state_width-1:0] st_idle = 3'd0;
	localparam logic [state_width-1:0] st_rd_addr = 3'd1;
	localparam logic [state_width-1:0] st_rd_data = 3'd2;
	localparam logic [state_width-1:0] st_wr_addr = 3'd3;
	localparam logic [state_width-1:0] st_wr_data = 3'd4;
	localparam logic [state_width-1:0] st_wr_resp = 3'd5;
	localparam logic [state_width-1:0] st_respond = 3'd6;

	// one bus beat, as raw bits or as byte lanes
	typedef union packed {
		logic [bus_width-1:0] raw;
		logic [lane_count-1:0][7:0] lanes;
	} bus_beat_t;

endpackage

`default_nettype wire

//--- hdl/txn_tag_counter.sv
`timescale 1ns/100ps
`default_nettype none

module txn_tag_counter
	import lsu_pkg::*;
(
	input  wire                  clock,
	input  wire                  reset,
	input  wire                  tag_issue,
	input  wire [tag_width-1:0]  rid,
	input  wire [tag_width-1:0]  bid,
	input  wire                  op_store,
	output logic [tag_width-1:0] tag,
	output logic                 id_match
);

	logic [tag_width-1:0] count_q;

	// free running, wraps
	always_ff @(posedge clock) begin
		if (reset) begin
			count_q <= '0;
		end else begin
			count_q <= count_q + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			tag <= '0;
		end else if (tag_issue) begin
			tag <= count_q;
		end
	end

	// write path answers on bid, read path on rid
	assign id_match = op_store ? (bid == tag) : (rid == tag);

endmodule

`default_nettype wire

//--- hdl/lane_mapper.sv
`timescale 1ns/100ps
`default_nettype none

module lane_mapper
	import lsu_pkg::*;
(
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   req_capture,
	input  wire [op_width-1:0]    req_op,
	input  wire [addr_width-1:0]  req_addr,
	input  wire [data_width-1:0]  req_wdata,
	input  wire                   second_beat,
	output logic [op_width-1:0]   op,
	output logic [2:0]            offset,
	output logic                  op_store,
	output logic                  need_split,
	output logic [addr_width-1:0] araddr,
	output logic [addr_width-1:0] awaddr,
	output logic [2:0]            arsize,
	output logic [2:0]            awsize,
	output bus_beat_t             wdata,
	output logic [lane_count-1:0] wstrb,
	output logic [lane_count-1:0] first_strb
);

	logic [addr_width-1:0] addr_q;
	logic [data_width-1:0] wdata_q;
	logic [addr_width-1:0] second_addr;
	logic [lane_count-1:0] second_strb;
	logic [2:0] size_code;
	logic [3:0] len_mask;
	logic [7:0] span;

	// ----------------------------------------
	// request register
	// ----------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			op <= op_lw;
		end else if (req_capture) begin
			op <= req_op;
		end
	end

	always_ff @(posedge clock) begin
		if (req_capture) begin
			addr_q <= req_addr;
			wdata_q <= req_wdata;
		end
	end

	assign offset = addr_q[2:0];
	assign op_store = op[op_width-1];

	always_comb begin
		case (op)
			op_lw, op_sw: begin
				size_code = size_word;
				len_mask = 4'b1111;
			end
			op_lh, op_lhu, op_sh: begin
				size_code = size_half;
				len_mask = 4'b0011;
			end
			default: begin
				size_code = size_byte;
				len_mask = 4'b0001;
			end
		endcase
	end

	assign arsize = size_code;
	assign awsize = size_code;

	// bytes within the aligned word, upper half is the spill-over
	assign span = {4'b0000, len_mask} << offset[1:0];
	assign need_split = |span[7:4];
	assign first_strb = offset[2] ? {span[3:0], 4'b0000} : {4'b0000, span[3:0]};
	assign second_strb = offset[2] ? {4'b0000, span[7:4]} : {span[7:4], 4'b0000};
	assign wstrb = second_beat ? second_strb : first_strb;

	// spill-over goes to the next aligned word
	assign second_addr = {addr_q[addr_width-1:2], 2'b00} + 32'd4;
	assign araddr = second_beat ? second_addr : addr_q;
	assign awaddr = araddr;

	// store byte i lands on lane offset + i, wrapping
	always_comb begin
		logic [2:0] lane;
		wdata = '0;
		for (int i = 0; i < data_width / 8; i++) begin
			lane = offset + 3'(i);
			wdata.lanes[lane] = wdata_q[8*i +: 8];
		end
	end

endmodule

`default_nettype wire

//--- hdl/load_merge.sv
`timescale 1ns/100ps
`default_nettype none

module load_merge
	import lsu_pkg::*;
(
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   first_capture,
	input  wire                   second_beat,
	input  wire [op_width-1:0]    op,
	input  wire [2:0]             offset,
	input  wire [lane_count-1:0]  first_strb,
	input  wire bus_beat_t        rdata,
	output logic [data_width-1:0] rsp_data
);

	bus_beat_t beat_q;
	logic [data_width-1:0] gathered;

	// ----------------------------------------
	// beat capture
	// ----------------------------------------
	// first beat is taken whole, the second one fills
	// only the lanes outside first_strb
	always_ff @(posedge clock) begin
		if (reset) begin
			beat_q <= '0;
		end else if (first_capture) begin
			for (int l = 0; l < lane_count; l++) begin
				if (!second_beat || !first_strb[l]) begin
					beat_q.lanes[l] <= rdata.lanes[l];
				end
			end
		end
	end

	// ----------------------------------------
	// byte gather
	// ----------------------------------------
	always_comb begin
		logic [2:0] lane;
		gathered = '0;
		for (int i = 0; i < data_width / 8; i++) begin
			lane = offset + 3'(i);
			gathered[8*i +: 8] = beat_q.lanes[lane];
		end
	end

	// extension by load type
	always_comb begin
		case (op)
			op_lw: begin
				rsp_data = gathered;
			end
			op_lh: begin
				rsp_data = {{(data_width - 16){gathered[15]}}, gathered[15:0]};
			end
			op_lhu: begin
				rsp_data = {{(data_width - 16){1'b0}}, gathered[15:0]};
			end
			op_lb: begin
				rsp_data = {{(data_width - 8){gathered[7]}}, gathered[7:0]};
			end
			op_lbu: begin
				rsp_data = {{(data_width - 8){1'b0}}, gathered[7:0]};
			end
			// stores return zero
			default: begin
				rsp_data = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/mem_access_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module mem_access_fsm
	import lsu_pkg::*;
(
	input  wire                clock,
	input  wire                reset,
	input  wire                req_valid,
	input  wire [op_width-1:0] req_op,
	input  wire                rsp_ready,
	input  wire                need_split,
	input  wire                op_store,
	input  wire                id_match,
	input  wire                arready,
	input  wire                rvalid,
	input  wire [1:0]          rresp,
	input  wire                awready,
	input  wire                wready,
	input  wire                bvalid,
	input  wire [1:0]          bresp,
	output logic               req_ready,
	output logic               rsp_valid,
	output logic               rsp_error,
	output logic               arvalid,
	output logic               rready,
	output logic               awvalid,
	output logic               wvalid,
	output logic               bready,
	output logic               req_capture,
	output logic               second_beat,
	output logic               first_capture,
	output logic               tag_issue
);

	logic [state_width-1:0] state;
	logic [state_width-1:0] state_next;
	logic err_q;
	logic rd_done;
	logic wr_done;
	logic beat_done;
	logic beat_err;

	// ----------------------------------------
	// handshake outputs
	// ----------------------------------------
	assign req_ready = (state == st_idle);
	assign req_capture = req_valid && req_ready;
	assign rready = (state == st_rd_data);
	assign wvalid = (state == st_wr_data);
	assign bready = (state == st_wr_resp);
	assign rsp_valid = (state == st_respond);
	assign rsp_error = err_q;

	// new tag in the first cycle of each address state
	assign tag_issue = ((state == st_rd_addr) && !arvalid) ||
		((state == st_wr_addr) && !awvalid);

	// responses with a foreign id are taken but do not count
	assign rd_done = rready && rvalid && id_match;
	assign wr_done = bready && bvalid && id_match;
	assign beat_done = rd_done || wr_done;
	assign beat_err = (rd_done && (rresp != resp_okay)) ||
		(wr_done && (bresp != resp_okay));
	assign first_capture = rd_done;

	// ----------------------------------------
	// next state
	// ----------------------------------------
	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (req_capture) begin
					state_next = req_op[op_width-1] ? st_wr_addr : st_rd_addr;
				end
			end
			st_rd_addr: begin
				if (arvalid && arready) begin
					state_next = st_rd_data;
				end
			end
			st_wr_addr: begin
				if (awvalid && awready) begin
					state_next = st_wr_data;
				end
			end
			st_wr_data: begin
				if (wready) begin
					state_next = st_wr_resp;
				end
			end
			st_rd_data, st_wr_resp: begin
				if (beat_done) begin
					// split access runs the same path once more
					if (need_split && !second_beat) begin
						state_next = op_store ? st_wr_addr : st_rd_addr;
					end else begin
						state_next = st_respond;
					end
				end
			end
			st_respond: begin
				if (rsp_ready) begin
					state_next = st_idle;
				end
			end
			default: state_next = st_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
			arvalid <= 1'b0;
			awvalid <= 1'b0;
		end else begin
			state <= state_next;
			// address valids come up one cycle into the address state
			if (arvalid && arready) begin
				arvalid <= 1'b0;
			end else if (state == st_rd_addr) begin
				arvalid <= 1'b1;
			end
			if (awvalid && awready) begin
				awvalid <= 1'b0;
			end else if (state == st_wr_addr) begin
				awvalid <= 1'b1;
			end
		end
	end

	// beat marker and sticky error, both per request
	always_ff @(posedge clock) begin
		if (reset) begin
			second_beat <= 1'b0;
			err_q <= 1'b0;
		end else if (req_capture) begin
			second_beat <= 1'b0;
			err_q <= 1'b0;
		end else begin
			if (beat_done && need_split && !second_beat) begin
				second_beat <= 1'b1;
			end
			if (beat_err) begin
				err_q <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/lsu_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_top
	import lsu_pkg::*;
(
	input  wire                   clock,
	input  wire                   reset,
	// request port
	input  wire                   req_valid,
	input  wire [op_width-1:0]    req_op,
	input  wire [addr_width-1:0]  req_addr,
	input  wire [data_width-1:0]  req_wdata,
	output logic                  req_ready,
	// response port
	output logic                  rsp_valid,
	output logic [data_width-1:0] rsp_data,
	output logic                  rsp_error,
	input  wire                   rsp_ready,
	// read address / read data
	output logic                  arvalid,
	input  wire                   arready,
	output logic [addr_width-1:0] araddr,
	output logic [2:0]            arsize,
	output logic [tag_width-1:0]  arid,
	output logic                  rready,
	input  wire                   rvalid,
	input  wire [bus_width-1:0]   rdata,
	input  wire [1:0]             rresp,
	input  wire [tag_width-1:0]   rid,
	// write address / write data / write response
	output logic                  awvalid,
	input  wire                   awready,
	output logic [addr_width-1:0] awaddr,
	output logic [2:0]            awsize,
	output logic [tag_width-1:0]  awid,
	output logic                  wvalid,
	input  wire                   wready,
	output logic [bus_width-1:0]  wdata,
	output logic [lane_count-1:0] wstrb,
	output logic                  bready,
	input  wire                   bvalid,
	input  wire [1:0]             bresp,
	input  wire [tag_width-1:0]   bid
);

	logic req_capture;
	logic second_beat;
	logic first_capture;
	logic tag_issue;
	logic id_match;
	logic need_split;
	logic op_store;
	logic [op_width-1:0] op;
	logic [2:0] offset;
	logic [lane_count-1:0] first_strb;
	logic [tag_width-1:0] tag;
	bus_beat_t rd_beat;
	bus_beat_t wr_beat;

	assign rd_beat.raw = rdata;
	assign wdata = wr_beat.raw;

	// both address channels carry the issued tag
	assign arid = tag;
	assign awid = tag;

	mem_access_fsm mem_access_fsm_i (
		.clock(clock),
		.reset(reset),
		.req_valid(req_valid),
		.req_op(req_op),
		.rsp_ready(rsp_ready),
		.need_split(need_split),
		.op_store(op_store),
		.id_match(id_match),
		.arready(arready),
		.rvalid(rvalid),
		.rresp(rresp),
		.awready(awready),
		.wready(wready),
		.bvalid(bvalid),
		.bresp(bresp),
		.req_ready(req_ready),
		.rsp_valid(rsp_valid),
		.rsp_error(rsp_error),
		.arvalid(arvalid),
		.rready(rready),
		.awvalid(awvalid),
		.wvalid(wvalid),
		.bready(bready),
		.req_capture(req_capture),
		.second_beat(second_beat),
		.first_capture(first_capture),
		.tag_issue(tag_issue)
	);

	txn_tag_counter txn_tag_counter_i (
		.clock(clock),
		.reset(reset),
		.tag_issue(tag_issue),
		.rid(rid),
		.bid(bid),
		.op_store(op_store),
		.tag(tag),
		.id_match(id_match)
	);

	lane_mapper lane_mapper_i (
		.clock(clock),
		.reset(reset),
		.req_capture(req_capture),
		.req_op(req_op),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.second_beat(second_beat),
		.op(op),
		.offset(offset),
		.op_store(op_store),
		.need_split(need_split),
		.araddr(araddr),
		.awaddr(awaddr),
		.arsize(arsize),
		.awsize(awsize),
		.wdata(wr_beat),
		.wstrb(wstrb),
		.first_strb(first_strb)
	);

	load_merge load_merge_i (
		.clock(clock),
		.reset(reset),
		.first_capture(first_capture),
		.second_beat(second_beat),
		.op(op),
		.offset(offset),
		.first_strb(first_strb),
		.rdata(rd_beat),
		.rsp_data(rsp_data)
	);

endmodule

`default_nettype wire

//--- bench/axi_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module axi_mem_model
	import lsu_pkg::*;
#(
	parameter logic [addr_width-1:0] err_addr = 32'h0000_0400
) (
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   stall_en,
	input  wire                   arvalid,
	output logic                  arready,
	input  wire [addr_width-1:0]  araddr,
	input  wire [2:0]             arsize,
	input  wire [tag_width-1:0]   arid,
	input  wire                   rready,
	output logic                  rvalid,
	output logic [bus_width-1:0]  rdata,
	output logic [1:0]            rresp,
	output logic [tag_width-1:0]  rid,
	input  wire                   awvalid,
	output logic                  awready,
	input  wire [addr_width-1:0]  awaddr,
	input  wire [2:0]             awsize,
	input  wire [tag_width-1:0]   awid,
	input  wire                   wvalid,
	output logic                  wready,
	input  wire [bus_width-1:0]   wdata,
	input  wire [lane_count-1:0]  wstrb,
	input  wire                   bready,
	output logic                  bvalid,
	output logic [1:0]            bresp,
	output logic [tag_width-1:0]  bid
);

	localparam int mem_size = 4096;
	localparam logic [1:0] resp_slverr = 2'b10;
	localparam logic [1:0] ph_idle = 2'd0;
	localparam logic [1:0] ph_rdata = 2'd1;
	localparam logic [1:0] ph_wdata = 2'd2;
	localparam logic [1:0] ph_bresp = 2'd3;

	logic [7:0] mem [0:mem_size-1];
	logic [1:0] phase;
	logic [1:0] delay;
	logic [addr_width-1:0] line_addr;
	logic line_err;
	// size code of the last accepted address
	logic [2:0] last_size;
	integer seed = 32'h441d_df39;
	int ar_count = 0;
	int aw_count = 0;

	// the whole 8-byte line of the error address answers with an error
	assign line_err = (line_addr[addr_width-1:3] == err_addr[addr_width-1:3]);

	function automatic logic [1:0] pick_delay();
		logic [31:0] r;
		r = $random(seed);
		return stall_en ? r[1:0] : 2'd0;
	endfunction

	function automatic logic [bus_width-1:0] read_line(input logic [addr_width-1:0] a);
		logic [bus_width-1:0] beat;
		for (int l = 0; l < lane_count; l++) begin
			beat[8*l +: 8] = mem[{a[11:3], 3'(l)}];
		end
		return beat;
	endfunction

	always @(posedge clock) begin
		if (reset) begin
			phase <= ph_idle;
			delay <= 2'd0;
			arready <= 1'b0;
			awready <= 1'b0;
			wready <= 1'b0;
			rvalid <= 1'b0;
			bvalid <= 1'b0;
			rdata <= '0;
			rresp <= resp_okay;
			bresp <= resp_okay;
			rid <= '0;
			bid <= '0;
			last_size <= '0;
		end else begin
			case (phase)
				ph_idle: begin
					if (arvalid && arready) begin
						arready <= 1'b0;
						line_addr <= araddr;
						last_size <= arsize;
						rid <= arid;
						ar_count <= ar_count + 1;
						delay <= pick_delay();
						phase <= ph_rdata;
					end else if (awvalid && awready) begin
						awready <= 1'b0;
						line_addr <= awaddr;
						last_size <= awsize;
						bid <= awid;
						aw_count <= aw_count + 1;
						delay <= pick_delay();
						phase <= ph_wdata;
					end else if ((arvalid || awvalid) && !arready && !awready) begin
						if (delay == 2'd0) begin
							arready <= arvalid;
							awready <= awvalid;
						end else begin
							delay <= delay - 2'd1;
						end
					end
				end
				ph_rdata: begin
					if (rvalid && rready) begin
						rvalid <= 1'b0;
						delay <= pick_delay();
						phase <= ph_idle;
					end else if (!rvalid) begin
						if (delay == 2'd0) begin
							rvalid <= 1'b1;
							rdata <= read_line(line_addr);
							rresp <= line_err ? resp_slverr : resp_okay;
						end else begin
							delay <= delay - 2'd1;
						end
					end
				end
				ph_wdata: begin
					if (wvalid && wready) begin
						wready <= 1'b0;
						// a failing beat leaves the array alone
						if (!line_err) begin
							for (int l = 0; l < lane_count; l++) begin
								if (wstrb[l]) begin
									mem[{line_addr[11:3], 3'(l)}] <= wdata[8*l +: 8];
								end
							end
						end
						bresp <= line_err ? resp_slverr : resp_okay;
						delay <= pick_delay();
						phase <= ph_bresp;
					end else if (wvalid) begin
						if (delay == 2'd0) begin
							wready <= 1'b1;
						end else begin
							delay <= delay - 2'd1;
						end
					end
				end
				default: begin
					if (bvalid && bready) begin
						bvalid <= 1'b0;
						delay <= pick_delay();
						phase <= ph_idle;
					end else if (!bvalid) begin
						if (delay == 2'd0) begin
							bvalid <= 1'b1;
						end else begin
							delay <= delay - 2'd1;
						end
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- bench/lsu_sva.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_sva (
	input wire clock,
	input wire reset,
	input wire arvalid,
	input wire arready,
	input wire awvalid,
	input wire awready,
	input wire second_beat,
	input wire rsp_valid,
	input wire rsp_ready,
	input wire rsp_error
);

	int assert_failures = 0;

	// ----------------------------------------
	// address channels
	// ----------------------------------------
	// address is the request register plus the second_beat select
	ar_hold: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(second_beat))
	else begin
		assert_failures++;
		$error("arvalid dropped or address changed before arready");
	end

	aw_hold: assert property (@(posedge clock) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable(second_beat))
	else begin
		assert_failures++;
		$error("awvalid dropped or address changed before awready");
	end

	addr_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(arvalid && awvalid))
	else begin
		assert_failures++;
		$error("arvalid and awvalid high together");
	end

	// result held under back-pressure
	rsp_hold: assert property (@(posedge clock) disable iff (reset)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_error))
	else begin
		assert_failures++;
		$error("rsp_valid or rsp_error changed before rsp_ready");
	end

endmodule

`default_nettype wire

//--- bench/lsu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_tb
	import lsu_pkg::*;
();

	localparam int clock_period = 10;
	localparam int drive_delay = 1;
	localparam int mem_size = 4096;
	localparam logic [addr_width-1:0] err_addr = 32'h0000_0400;
	// requests per test, in the order the tests run
	localparam int request_total = 2 + 18 + 32 + 18 + 32 + 4;

	logic clock = 1'b0;
	logic reset;
	logic stall_en;
	logic req_valid;
	logic [op_width-1:0] req_op;
	logic [addr_width-1:0] req_addr;
	logic [data_width-1:0] req_wdata;
	logic req_ready;
	logic rsp_valid;
	logic [data_width-1:0] rsp_data;
	logic rsp_error;
	logic rsp_ready;
	logic arvalid;
	logic arready;
	logic [addr_width-1:0] araddr;
	logic [2:0] arsize;
	logic [tag_width-1:0] arid;
	logic rready;
	logic rvalid;
	logic [bus_width-1:0] rdata;
	logic [1:0] rresp;
	logic [tag_width-1:0] rid;
	logic awvalid;
	logic awready;
	logic [addr_width-1:0] awaddr;
	logic [2:0] awsize;
	logic [tag_width-1:0] awid;
	logic wvalid;
	logic wready;
	logic [bus_width-1:0] wdata;
	logic [lane_count-1:0] wstrb;
	logic bready;
	logic bvalid;
	logic [1:0] bresp;
	logic [tag_width-1:0] bid;

	logic [7:0] mirror [0:mem_size-1];
	integer seed = 32'h441d_df39;

	lsu_top lsu_top_i (.*);

	axi_mem_model #(.err_addr(err_addr)) mem_i (.*);

	bind mem_access_fsm lsu_sva lsu_sva_i (.*);

	always #(clock_period / 2) clock = ~clock;

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	task automatic compare(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("TEST FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic step_cycle();
		@(posedge clock);
		#drive_delay;
	endtask

	task automatic preload_byte(input int a, input logic [7:0] value);
		mirror[a] = value;
		mem_i.mem[a] = value;
	endtask

	function automatic int access_len(input logic [op_width-1:0] op);
		case (op)
			op_lw, op_sw: return 4;
			op_lh, op_lhu, op_sh: return 2;
			default: return 1;
		endcase
	endfunction

	// bus size code for one access
	function automatic logic [2:0] size_for(input logic [op_width-1:0] op);
		case (access_len(op))
			4: return size_word;
			2: return size_half;
			default: return size_byte;
		endcase
	endfunction

	// bus transactions expected for one access
	function automatic int beats_for(input logic [op_width-1:0] op,
			input logic [addr_width-1:0] addr);
		if (access_len(op) == 4) begin
			return (addr[2:0] == 3'd0 || addr[2:0] == 3'd4) ? 1 : 2;
		end
		if (access_len(op) == 2) begin
			return (addr[2:0] == 3'd3 || addr[2:0] == 3'd7) ? 2 : 1;
		end
		return 1;
	endfunction

	// little endian gather from the mirror, then extension
	function automatic logic [31:0] expected_load(input logic [op_width-1:0] op,
			input logic [addr_width-1:0] addr);
		logic [31:0] word;
		for (int i = 0; i < 4; i++) begin
			word[8*i +: 8] = mirror[addr[11:0] + 12'(i)];
		end
		case (op)
			op_lh: return {{16{word[15]}}, word[15:0]};
			op_lhu: return {16'h0000, word[15:0]};
			op_lb: return {{24{word[7]}}, word[7:0]};
			op_lbu: return {24'h000000, word[7:0]};
			default: return word;
		endcase
	endfunction

	task automatic mirror_store(input logic [op_width-1:0] op,
			input logic [addr_width-1:0] addr, input logic [31:0] data);
		for (int i = 0; i < access_len(op); i++) begin
			mirror[addr[11:0] + 12'(i)] = data[8*i +: 8];
		end
	endtask

	// one request, with rsp_ready held low for hold cycles
	task automatic access(input logic [op_width-1:0] op, input logic [addr_width-1:0] addr,
			input logic [31:0] data, input int hold, input logic exp_err);
		int txn_before;
		logic [31:0] exp_data;
		logic [31:0] held_data;
		txn_before = mem_i.ar_count + mem_i.aw_count;
		exp_data = expected_load(op, addr);
		req_valid = 1'b1;
		req_op = op;
		req_addr = addr;
		req_wdata = data;
		rsp_ready = (hold == 0);
		while (!req_ready) begin
			step_cycle();
		end
		step_cycle();
		req_valid = 1'b0;
		while (!rsp_valid) begin
			step_cycle();
		end
		held_data = rsp_data;
		for (int c = 0; c < hold; c++) begin
			compare("req_ready", req_ready, 0);
			step_cycle();
			compare("rsp_valid", rsp_valid, 1);
			compare("rsp_data", rsp_data, held_data);
		end
		compare("rsp_error", rsp_error, exp_err);
		if (!op[op_width-1] && !exp_err) begin
			compare("rsp_data", rsp_data, exp_data);
		end
		compare("bus transactions", mem_i.ar_count + mem_i.aw_count - txn_before,
			beats_for(op, addr));
		if (op[op_width-1]) begin
			compare("awsize", mem_i.last_size, size_for(op));
		end else begin
			compare("arsize", mem_i.last_size, size_for(op));
		end
		rsp_ready = 1'b1;
		step_cycle();
		compare("rsp_valid", rsp_valid, 0);
		if (op[op_width-1] && !exp_err) begin
			mirror_store(op, addr, data);
		end
	endtask

	// ----------------------------------------
	// tests
	// ----------------------------------------
	task automatic aligned_word_roundtrip();
		access(op_sw, 32'h100, 32'hdead_beef, 0, 1'b0);
		access(op_lw, 32'h100, 32'h0, 0, 1'b0);
		for (int a = 'h100; a < 'h108; a++) begin
			compare("mem byte", mem_i.mem[a], mirror[a]);
		end
	endtask

	task automatic split_roundtrip();
		int offsets [6] = '{1, 2, 3, 5, 6, 7};
		logic [addr_width-1:0] addr;
		logic [31:0] data;
		for (int k = 0; k < 6; k++) begin
			addr = 32'h200 + 32'(16 * k + offsets[k]);
			data = $random(seed);
			access(op_sw, addr, data, 0, 1'b0);
			access(op_lw, addr, 32'h0, 0, 1'b0);
		end
		for (int k = 0; k < 2; k++) begin
			addr = (k == 0) ? 32'h2c3 : 32'h2d7;
			data = $random(seed);
			access(op_sh, addr, data, 0, 1'b0);
			access(op_lh, addr, 32'h0, 0, 1'b0);
			access(op_lhu, addr, 32'h0, 0, 1'b0);
		end
	endtask

	task automatic load_extension();
		for (int a = 'h300; a < 'h30c; a++) begin
			preload_byte(a, 8'h80 | 8'(a * 5));
		end
		for (int off = 0; off < 8; off++) begin
			access(op_lh, 32'h300 + 32'(off), 32'h0, 0, 1'b0);
			access(op_lhu, 32'h300 + 32'(off), 32'h0, 0, 1'b0);
			access(op_lb, 32'h300 + 32'(off), 32'h0, 0, 1'b0);
			access(op_lbu, 32'h300 + 32'(off), 32'h0, 0, 1'b0);
		end
	endtask

	task automatic byte_lane_merge();
		access(op_sw, 32'h180, 32'h0, 0, 1'b0);
		access(op_sw, 32'h184, 32'h0, 0, 1'b0);
		// upper store bits carry junk that must not land anywhere
		for (int lane = 0; lane < 8; lane++) begin
			access(op_sb, 32'h180 + 32'(lane), 32'hffff_ff00 | 32'(8'h11 * (lane + 1)), 0, 1'b0);
			access(op_lw, 32'h180 + 32'(lane & 4), 32'h0, 0, 1'b0);
		end
	endtask

	task automatic backpressure_roundtrip();
		logic [addr_width-1:0] addr;
		logic [31:0] data;
		stall_en = 1'b1;
		for (int off = 0; off < 8; off++) begin
			addr = 32'h500 + 32'(17 * off);
			data = $random(seed);
			access(op_sw, addr, data, 3, 1'b0);
			access(op_lw, addr, 32'h0, 3, 1'b0);
			access(op_lh, addr, 32'h0, 2, 1'b0);
			access(op_lbu, 32'h300 + 32'(off), 32'h0, 4, 1'b0);
		end
		stall_en = 1'b0;
	endtask

	task automatic error_responses();
		access(op_lw, err_addr, 32'h0, 0, 1'b1);
		access(op_sw, err_addr + 32'd4, 32'h1234_5678, 0, 1'b1);
		compare("mem byte", mem_i.mem[err_addr + 4], mirror[err_addr + 4]);
		// offset 5, only the second beat reaches the error line
		access(op_lw, err_addr - 32'd3, 32'h0, 0, 1'b1);
		access(op_lw, 32'h100, 32'h0, 0, 1'b0);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		reset = 1'b1;
		stall_en = 1'b0;
		req_valid = 1'b0;
		req_op = op_lw;
		req_addr = '0;
		req_wdata = '0;
		rsp_ready = 1'b1;
		for (int a = 0; a < mem_size; a++) begin
			preload_byte(a, 8'(a * 13 + (a >> 8)));
		end
		repeat (5) @(posedge clock);
		#drive_delay;
		reset = 1'b0;
		compare("req_ready", req_ready, 1);
		compare("bus valids", {arvalid, awvalid, wvalid, rready, bready, rsp_valid}, 0);
		aligned_word_roundtrip();
		split_roundtrip();
		load_extension();
		byte_lane_merge();
		backpressure_roundtrip();
		error_responses();
		step_cycle();
		if (lsu_top_i.mem_access_fsm_i.lsu_sva_i.assert_failures != 0) begin
			$display("%0d assertion failures during the run",
				lsu_top_i.mem_access_fsm_i.lsu_sva_i.assert_failures);
			$display("TEST FAIL");
			$fatal(1, "assertions failed");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

	// watchdog
	initial begin
		#(request_total * 200 * clock_period);
		$display("timeout: requests did not finish within %0d cycles", request_total * 200);
		$display("TEST FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

//--- lsu_top.f
hdl/lsu_pkg.sv
hdl/txn_tag_counter.sv
hdl/lane_mapper.sv
hdl/load_merge.sv
hdl/mem_access_fsm.sv
hdl/lsu_top.sv
bench/axi_mem_model.sv
bench/lsu_sva.sv
bench/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu_top

sources:
  - hdl/lsu_pkg.sv
  - hdl/txn_tag_counter.sv
  - hdl/lane_mapper.sv
  - hdl/load_merge.sv
  - hdl/mem_access_fsm.sv
  - hdl/lsu_top.sv
  - target: test
    files:
      - bench/axi_mem_model.sv
      - bench/lsu_sva.sv
      - bench/lsu_tb.sv
